//--- logic/sau_issue_ctrl.sv
// Issue control that pipelines done, destination and tag and derives the byte write enables
module sau_issue_ctrl (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                issue_i,
	input  sau_pkg::prec_t      prec_i,
	input  sau_pkg::regno_t     rd_i,
	input  sau_pkg::mode_t      mode_i,
	input  sau_pkg::tag_t       tag_i,
	output logic                done_o,
	output sau_pkg::byte_mask_t we_o,
	output sau_pkg::regno_t     rd_o,
	output sau_pkg::tag_t       tag_o
);
	import sau_pkg::*;

	byte_mask_t we_next;
	logic       priv_rd;

	// ========================================
	// Write enable decode
	// ========================================

	// The top eight registers are the privileged block
	assign priv_rd = (rd_i >= PRIV_REG_FIRST) && (rd_i <= PRIV_REG_LAST);

	// Register 0 is hardwired, privileged registers open up one byte
	// more per mode level, and secure mode writes all of them
	always_comb begin
		we_next = 8'hFF;
		if (rd_i == '0) begin
			we_next = 8'h00;
		end else if (priv_rd) begin
			case (mode_i)
				MODE_APP:    we_next = 8'h01;
				MODE_SUPER:  we_next = 8'h03;
				MODE_HYPER:  we_next = 8'h07;
				MODE_SECURE: we_next = 8'hFF;
			endcase
		end
	end

	// ========================================
	// Pipeline registers
	// ========================================

	// Done and write enables drop on any cycle without an issue
	always_ff @(posedge clk) begin
		if (rst_i) begin
			done_o <= 1'b0;
			we_o   <= '0;
		end else begin
			done_o <= issue_i;
			we_o   <= issue_i ? we_next : '0;
		end
	end

	// Destination and tag only matter while done is high
	always_ff @(posedge clk) begin
		if (issue_i) begin
			rd_o  <= rd_i;
			tag_o <= tag_i;
		end
	end

	// ========================================
	// Issue rules
	// ========================================

	// The merge block would quietly treat code 3 as 64-bit, so it must never issue
	a_legal_prec: assert property (@(posedge clk) disable iff (rst_i)
		issue_i |-> (prec_i <= PREC_OCTA));

endmodule

//--- logic/sau_lane_alu.sv
// Combinational SIMD lane ALU producing one lane result and its fault code
module sau_lane_alu #(
	parameter int LANE_W = 16
) (
	input  sau_pkg::opcode_t  op_i,
	input  logic [LANE_W-1:0] a_i,
	input  logic [LANE_W-1:0] b_i,
	output logic [LANE_W-1:0] res_o,
	output sau_pkg::fault_t   fault_o
);
	import sau_pkg::*;

	// Enough bits to shift by any amount below the lane width
	localparam int SH_W = $clog2(LANE_W);

	logic [SH_W-1:0]   shamt;
	logic [LANE_W-1:0] sum;
	logic [LANE_W-1:0] diff;
	logic              sign_a;
	logic              sign_b;
	logic              add_ovf;
	logic              sub_ovf;

	// ========================================
	// Shared arithmetic
	// ========================================

	// Shift amount wraps modulo the lane width by dropping the upper bits
	assign shamt = b_i[SH_W-1:0];

	// Both adders wrap inside the lane, carries never leave it
	assign sum  = a_i + b_i;
	assign diff = a_i - b_i;

	assign sign_a = a_i[LANE_W-1];
	assign sign_b = b_i[LANE_W-1];

	// Addition overflows when the operands agree in sign and the sum does not
	assign add_ovf = (sign_a == sign_b) && (sum[LANE_W-1] != sign_a);

	// Subtraction overflows when the operands differ in sign
	// and the difference takes the sign of b
	assign sub_ovf = (sign_a != sign_b) && (diff[LANE_W-1] != sign_a);

	// ========================================
	// Operation select
	// ========================================

	always_comb begin
		res_o   = '0;
		fault_o = FLT_NONE;
		case (op_i)
			OP_ADD: res_o = sum;
			OP_SUB: res_o = diff;
			OP_AND: res_o = a_i & b_i;
			OP_OR:  res_o = a_i | b_i;
			OP_XOR: res_o = a_i ^ b_i;
			// Logical shifts, zeros come in from either end
			OP_SLL: res_o = a_i << shamt;
			OP_SRL: res_o = a_i >> shamt;
			OP_ADDV: begin
				res_o = sum;
				if (add_ovf) begin
					fault_o = FLT_OVERFLOW;
				end
			end
			OP_SUBV: begin
				res_o = diff;
				if (sub_ovf) begin
					fault_o = FLT_OVERFLOW;
				end
			end
			default: begin
				// Undefined opcode leaves the result at zero
				fault_o = FLT_ILLEGAL;
			end
		endcase
	end

endmodule

//--- logic/sau_lane_merge.sv
// Lane result merge that picks the precision, applies the byte mask and squashes masked faults
module sau_lane_merge (
	input  logic               clk,
	input  logic               rst_i,
	input  sau_pkg::prec_t     prec_i,
	input  sau_pkg::word_t     res16_i,
	input  sau_pkg::word_t     res32_i,
	input  sau_pkg::word_t     res64_i,
	input  sau_pkg::exc_vec_t  exc16_i,
	input  sau_pkg::exc_vec_t  exc32_i,
	input  sau_pkg::exc_vec_t  exc64_i,
	input  sau_pkg::word_t     t_i,
	input  sau_pkg::byte_mask_t mask_i,
	input  logic               zero_i,
	output sau_pkg::word_t     result_o,
	output sau_pkg::exc_vec_t  exc_o
);
	import sau_pkg::*;

	localparam int FW     = $bits(fault_t);
	localparam int NSLOT  = $bits(exc_vec_t) / FW;
	localparam int NBYTE  = $bits(byte_mask_t);

	word_t      sel_res;
	exc_vec_t   sel_exc;
	word_t      merged;
	exc_vec_t   squashed;
	logic [3:0] wyde_full;
	logic [1:0] tetra_full;
	logic [NSLOT-1:0] slot_full;

	// ========================================
	// Precision select
	// ========================================

	// The reserved precision code falls back to the 64-bit lane
	always_comb begin
		case (prec_i)
			PREC_WYDE: begin
				sel_res = res16_i;
				sel_exc = exc16_i;
			end
			PREC_TETRA: begin
				sel_res = res32_i;
				sel_exc = exc32_i;
			end
			default: begin
				sel_res = res64_i;
				sel_exc = exc64_i;
			end
		endcase
	end

	// ========================================
	// Byte mask merge
	// ========================================

	// A masked byte keeps the old target, or reads as zero when zeroing is on
	for (genvar j = 0; j < NBYTE; j++) begin : g_byte
		assign merged[j*8 +: 8] = mask_i[j] ? (zero_i ? 8'h00 : t_i[j*8 +: 8])
			: sel_res[j*8 +: 8];
	end

	// ========================================
	// Fault squash
	// ========================================

	// A 16-bit lane is fully masked when both of its bytes are masked
	for (genvar w = 0; w < 4; w++) begin : g_wyde
		assign wyde_full[w] = &mask_i[w*2 +: 2];
	end

	// 32-bit lanes cover four bytes each
	for (genvar t = 0; t < 2; t++) begin : g_tetra
		assign tetra_full[t] = &mask_i[t*4 +: 4];
	end

	// Slots past the lane count never see a fault, so their flag stays low
	always_comb begin
		case (prec_i)
			PREC_WYDE:  slot_full = {4'b0000, wyde_full};
			PREC_TETRA: slot_full = {6'b000000, tetra_full};
			default:    slot_full = {7'b0000000, &mask_i};
		endcase
	end

	// A lane that writes none of its bytes cannot raise a fault
	for (genvar k = 0; k < NSLOT; k++) begin : g_slot
		assign squashed[k*FW +: FW] = slot_full[k] ? FLT_NONE : sel_exc[k*FW +: FW];
	end

	// ========================================
	// Output register
	// ========================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			result_o <= '0;
			exc_o    <= '0;
		end else begin
			result_o <= merged;
			exc_o    <= squashed;
		end
	end

	// ========================================
	// Input checks
	// ========================================

	// The squash only covers real lanes, so slots without a lane must arrive clear
	a_idle_slots_clear: assert property (@(posedge clk) disable iff (rst_i)
		(exc16_i[31:16] == '0) && (exc32_i[31:8] == '0) && (exc64_i[31:4] == '0));

endmodule

//--- logic/sau_pkg.sv
// SIMD integer unit package with the shared widths, opcodes, precisions, modes and fault codes
package sau_pkg;

	// ========================================
	// Datapath types
	// ========================================

	// One full 64-bit operand, target or result word
	typedef logic [63:0] word_t;

	// One bit per byte lane, used for the merge mask and the write enables
	typedef logic [7:0] byte_mask_t;

	// Architectural destination register number
	typedef logic [5:0] regno_t;

	// Opaque tag that travels with an instruction through the unit
	typedef logic [3:0] tag_t;

	// ========================================
	// Operation encodings
	// ========================================

	typedef logic [3:0] opcode_t;

	// Plain wrapping arithmetic and logic
	localparam opcode_t OP_ADD  = 4'd0;
	localparam opcode_t OP_SUB  = 4'd1;
	localparam opcode_t OP_AND  = 4'd2;
	localparam opcode_t OP_OR   = 4'd3;
	localparam opcode_t OP_XOR  = 4'd4;

	// Shifts take their amount from the low bits of the lane's b operand
	localparam opcode_t OP_SLL  = 4'd5;
	localparam opcode_t OP_SRL  = 4'd6;

	// Add and subtract that trap on signed overflow inside the lane
	localparam opcode_t OP_ADDV = 4'd7;
	localparam opcode_t OP_SUBV = 4'd8;

	// Lane precision, code 3 is reserved and must not be issued
	typedef logic [1:0] prec_t;

	localparam prec_t PREC_WYDE  = 2'd0;
	localparam prec_t PREC_TETRA = 2'd1;
	localparam prec_t PREC_OCTA  = 2'd2;

	// Operating mode, ordered from least to most privileged
	typedef logic [1:0] mode_t;

	localparam mode_t MODE_APP    = 2'd0;
	localparam mode_t MODE_SUPER  = 2'd1;
	localparam mode_t MODE_HYPER  = 2'd2;
	localparam mode_t MODE_SECURE = 2'd3;

	// ========================================
	// Faults and register classes
	// ========================================

	typedef logic [3:0] fault_t;

	localparam fault_t FLT_NONE     = 4'd0;
	localparam fault_t FLT_OVERFLOW = 4'd1;
	localparam fault_t FLT_ILLEGAL  = 4'd2;

	// Eight fault slots, slot k in bits 4k+3 down to 4k
	typedef logic [31:0] exc_vec_t;

	// Registers in this range need a privileged mode for a full write
	localparam regno_t PRIV_REG_FIRST = 6'd56;
	localparam regno_t PRIV_REG_LAST  = 6'd63;

endpackage

//--- logic/sau_top.sv
// Top level of the 64-bit SIMD integer unit with lane ALUs at 16, 32 and 64 bits
module sau_top (
	input  logic                clk,
	input  logic                rst_i,
	input  logic                issue_i,
	input  sau_pkg::opcode_t    op_i,
	input  sau_pkg::prec_t      prec_i,
	input  sau_pkg::word_t      a_i,
	input  sau_pkg::word_t      b_i,
	input  sau_pkg::word_t      t_i,
	input  sau_pkg::byte_mask_t mask_i,
	input  logic                zero_i,
	input  sau_pkg::regno_t     rd_i,
	input  sau_pkg::mode_t      mode_i,
	input  sau_pkg::tag_t       tag_i,
	output logic                done_o,
	output sau_pkg::word_t      result_o,
	output sau_pkg::exc_vec_t   exc_o,
	output sau_pkg::byte_mask_t we_o,
	output sau_pkg::regno_t     rd_o,
	output sau_pkg::tag_t       tag_o
);
	import sau_pkg::*;

	// Lane counts at each width over the fixed 64-bit word
	localparam int N16   = $bits(word_t) / 16;
	localparam int N32   = $bits(word_t) / 32;
	localparam int N64   = $bits(word_t) / 64;
	localparam int FW    = $bits(fault_t);
	localparam int NSLOT = $bits(exc_vec_t) / FW;

	word_t    res16;
	word_t    res32;
	word_t    res64;
	exc_vec_t exc16;
	exc_vec_t exc32;
	exc_vec_t exc64;

	// ========================================
	// Lane ALUs
	// ========================================

	// All three widths compute in parallel, the merge block picks one
	for (genvar g = 0; g < N16; g++) begin : g_lane16
		sau_lane_alu #(.LANE_W(16)) u_alu (
			.op_i    (op_i),
			.a_i     (a_i[g*16 +: 16]),
			.b_i     (b_i[g*16 +: 16]),
			.res_o   (res16[g*16 +: 16]),
			.fault_o (exc16[g*FW +: FW])
		);
	end

	for (genvar g = 0; g < N32; g++) begin : g_lane32
		sau_lane_alu #(.LANE_W(32)) u_alu (
			.op_i    (op_i),
			.a_i     (a_i[g*32 +: 32]),
			.b_i     (b_i[g*32 +: 32]),
			.res_o   (res32[g*32 +: 32]),
			.fault_o (exc32[g*FW +: FW])
		);
	end

	for (genvar g = 0; g < N64; g++) begin : g_lane64
		sau_lane_alu #(.LANE_W(64)) u_alu (
			.op_i    (op_i),
			.a_i     (a_i[g*64 +: 64]),
			.b_i     (b_i[g*64 +: 64]),
			.res_o   (res64[g*64 +: 64]),
			.fault_o (exc64[g*FW +: FW])
		);
	end

	// Fault slots with no lane behind them read as no fault
	assign exc16[$bits(exc_vec_t)-1:N16*FW] = {(NSLOT - N16){FLT_NONE}};
	assign exc32[$bits(exc_vec_t)-1:N32*FW] = {(NSLOT - N32){FLT_NONE}};
	assign exc64[$bits(exc_vec_t)-1:N64*FW] = {(NSLOT - N64){FLT_NONE}};

	// ========================================
	// Merge and control
	// ========================================

	sau_lane_merge u_merge (
		.clk      (clk),
		.rst_i    (rst_i),
		.prec_i   (prec_i),
		.res16_i  (res16),
		.res32_i  (res32),
		.res64_i  (res64),
		.exc16_i  (exc16),
		.exc32_i  (exc32),
		.exc64_i  (exc64),
		.t_i      (t_i),
		.mask_i   (mask_i),
		.zero_i   (zero_i),
		.result_o (result_o),
		.exc_o    (exc_o)
	);

	sau_issue_ctrl u_issue (
		.clk     (clk),
		.rst_i   (rst_i),
		.issue_i (issue_i),
		.prec_i  (prec_i),
		.rd_i    (rd_i),
		.mode_i  (mode_i),
		.tag_i   (tag_i),
		.done_o  (done_o),
		.we_o    (we_o),
		.rd_o    (rd_o),
		.tag_o   (tag_o)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the SIMD unit testbench with Verilator, runs it and checks the verdict

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module sau_tb -f sau.f -o sau_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sau_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi

//--- sau.f
logic/sau_pkg.sv
logic/sau_lane_alu.sv
logic/sau_lane_merge.sv
logic/sau_issue_ctrl.sv
logic/sau_top.sv
tests/sau_tb.sv

//--- tests/sau_tb.sv
// Directed testbench for the SIMD integer unit with a lane reference model and final verdict
module sau_tb;
	import sau_pkg::*;

	// Generous bound well above the length of all tests together
	localparam int MAX_CYCLES = 2000;

	logic       clk;
	logic       rst_i;
	logic       issue_i;
	opcode_t    op_i;
	prec_t      prec_i;
	word_t      a_i;
	word_t      b_i;
	word_t      t_i;
	byte_mask_t mask_i;
	logic       zero_i;
	regno_t     rd_i;
	mode_t      mode_i;
	tag_t       tag_i;
	logic       done_o;
	word_t      result_o;
	exc_vec_t   exc_o;
	byte_mask_t we_o;
	regno_t     rd_o;
	tag_t       tag_o;

	integer seed;
	int     errors;
	int     checks;
	int     tests_run;
	int     cycle_count;
	logic   issued_now;
	logic   issued_prev;

	// Expected responses in issue order, popped on each done pulse
	word_t      exp_res_q[$];
	exc_vec_t   exp_exc_q[$];
	byte_mask_t exp_we_q[$];
	regno_t     exp_rd_q[$];
	tag_t       exp_tag_q[$];

	sau_top dut_i (
		.clk(clk), .rst_i(rst_i), .issue_i(issue_i), .op_i(op_i), .prec_i(prec_i),
		.a_i(a_i), .b_i(b_i), .t_i(t_i), .mask_i(mask_i), .zero_i(zero_i),
		.rd_i(rd_i), .mode_i(mode_i), .tag_i(tag_i), .done_o(done_o),
		.result_o(result_o), .exc_o(exc_o), .we_o(we_o), .rd_o(rd_o), .tag_o(tag_o)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Hard stop if the tests stall for any reason
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ========================================
	// Reference model and checking
	// ========================================

	// Recomputes each lane by shifting it down to bit 0, then applies mask, squash and enables
	task automatic model(input opcode_t op, input prec_t prec, input word_t a, input word_t b,
		input word_t t, input byte_mask_t mask, input logic zero, input regno_t rd,
		input mode_t mode, output word_t res, output exc_vec_t exc, output byte_mask_t we);
		int          w;
		int          nb;
		int          sh;
		logic [63:0] lm;
		logic [63:0] la;
		logic [63:0] lb;
		logic [63:0] lr;
		logic [63:0] raw;
		fault_t      f;
		logic        full;
		w   = 16 << prec;
		nb  = w / 8;
		lm  = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
		raw = '0;
		exc = '0;
		for (int k = 0; k < 64 / w; k++) begin
			la = (a >> (k * w)) & lm;
			lb = (b >> (k * w)) & lm;
			sh = int'(lb[5:0]) % w;
			lr = '0;
			f  = FLT_NONE;
			case (op)
				OP_ADD: lr = (la + lb) & lm;
				OP_SUB: lr = (la - lb) & lm;
				OP_AND: lr = la & lb;
				OP_OR:  lr = la | lb;
				OP_XOR: lr = la ^ lb;
				OP_SLL: lr = (la << sh) & lm;
				OP_SRL: lr = la >> sh;
				OP_ADDV: begin
					lr = (la + lb) & lm;
					if (la[w-1] == lb[w-1] && lr[w-1] != la[w-1]) f = FLT_OVERFLOW;
				end
				OP_SUBV: begin
					lr = (la - lb) & lm;
					if (la[w-1] != lb[w-1] && lr[w-1] != la[w-1]) f = FLT_OVERFLOW;
				end
				default: f = FLT_ILLEGAL;
			endcase
			// A lane with every byte masked reports no fault
			full = 1'b1;
			for (int j = k * nb; j < (k + 1) * nb; j++) begin
				if (!mask[j]) full = 1'b0;
			end
			if (full) f = FLT_NONE;
			raw = raw | (lr << (k * w));
			exc[k*4 +: 4] = f;
		end
		for (int j = 0; j < 8; j++) begin
			res[j*8 +: 8] = mask[j] ? (zero ? 8'h00 : t[j*8 +: 8]) : raw[j*8 +: 8];
		end
		if (rd == 6'd0) begin
			we = 8'h00;
		end else if (rd >= PRIV_REG_FIRST) begin
			case (mode)
				MODE_APP:   we = 8'h01;
				MODE_SUPER: we = 8'h03;
				MODE_HYPER: we = 8'h07;
				default:    we = 8'hFF;
			endcase
		end else begin
			we = 8'hFF;
		end
	endtask

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks = checks + 1;
		if (act !== exp) begin
			errors = errors + 1;
			$display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
		end
	endtask

	// Compares outputs against whatever was issued on the edge before the last one
	task automatic collect();
		if (issued_prev) begin
			check("done_o", 64'(1'b1), 64'(done_o));
			if (exp_res_q.size() == 0) begin
				errors = errors + 1;
				$display("Internal problem: a done pulse was expected but no response is queued");
			end else begin
				check("result_o", exp_res_q.pop_front(), result_o);
				check("exc_o", 64'(exp_exc_q.pop_front()), 64'(exc_o));
				check("we_o", 64'(exp_we_q.pop_front()), 64'(we_o));
				check("rd_o", 64'(exp_rd_q.pop_front()), 64'(rd_o));
				check("tag_o", 64'(exp_tag_q.pop_front()), 64'(tag_o));
			end
		end else begin
			check("done_o", 64'(1'b0), 64'(done_o));
			check("we_o", 64'(8'h00), 64'(we_o));
		end
	endtask

	// One issue per clock, checking the previous issue's response on the same cycle
	task automatic send(input opcode_t op, input prec_t prec, input word_t a, input word_t b,
		input word_t t, input byte_mask_t mask, input logic zero, input regno_t rd,
		input mode_t mode, input tag_t tag);
		word_t      er;
		exc_vec_t   ee;
		byte_mask_t ew;
		model(op, prec, a, b, t, mask, zero, rd, mode, er, ee, ew);
		@(posedge clk);
		issue_i <= 1'b1;
		op_i    <= op;
		prec_i  <= prec;
		a_i     <= a;
		b_i     <= b;
		t_i     <= t;
		mask_i  <= mask;
		zero_i  <= zero;
		rd_i    <= rd;
		mode_i  <= mode;
		tag_i   <= tag;
		exp_res_q.push_back(er);
		exp_exc_q.push_back(ee);
		exp_we_q.push_back(ew);
		exp_rd_q.push_back(rd);
		exp_tag_q.push_back(tag);
		issued_prev = issued_now;
		issued_now  = 1'b1;
		@(negedge clk);
		collect();
	endtask

	task automatic idle();
		@(posedge clk);
		issue_i <= 1'b0;
		issued_prev = issued_now;
		issued_now  = 1'b0;
		@(negedge clk);
		collect();
	endtask

	function automatic word_t rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	task automatic report_test(input string name, input int err_before);
		tests_run = tests_run + 1;
		$display("%s finished with %0d errors", name, errors - err_before);
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic test_reset();
		int e0;
		e0 = errors;
		repeat (15) begin
			@(posedge clk);
			@(negedge clk);
			check("done_o", 64'(1'b0), 64'(done_o));
			check("we_o", 64'(8'h00), 64'(we_o));
			check("result_o", 64'd0, result_o);
			check("exc_o", 64'd0, 64'(exc_o));
		end
		@(posedge clk);
		rst_i <= 1'b0;
		@(negedge clk);
		check("done_o", 64'(1'b0), 64'(done_o));
		// Idle cycles right after reset must not produce a done pulse
		repeat (4) idle();
		report_test("reset", e0);
	endtask

	task automatic test_octa();
		int e0;
		e0 = errors;
		for (int i = 0; i < 9; i++) begin
			send(opcode_t'(i), PREC_OCTA, rand_word(), rand_word(), rand_word(), 8'h00, 1'b0,
				6'd5, MODE_APP, tag_t'(i));
		end
		idle();
		report_test("octa ops", e0);
	endtask

	// Operands put carries, borrows and shifted bits right at the lane edges
	task automatic test_lanes();
		int e0;
		e0 = errors;
		send(OP_ADD, PREC_WYDE, 64'hFFFF_7FFF_FFFF_0001, 64'h0001_0001_0002_FFFF,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd1);
		send(OP_SUB, PREC_WYDE, 64'h0000_8000_0001_0000, 64'h0001_0001_0002_0001,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd2);
		send(OP_SLL, PREC_WYDE, 64'h8001_C003_00FF_1234, 64'h0001_0011_0008_000F,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd3);
		send(OP_SRL, PREC_WYDE, 64'h8001_C003_FF00_1234, 64'h0001_0021_0008_0004,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd4);
		send(OP_ADD, PREC_TETRA, 64'hFFFF_FFFF_0000_0001, 64'h0000_0001_FFFF_FFFF,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd5);
		send(OP_SUB, PREC_TETRA, 64'h0000_0000_0000_0001, 64'h0000_0001_0000_0002,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd6);
		send(OP_SLL, PREC_TETRA, 64'h8000_0001_FFFF_FFFF, 64'h0000_0021_0000_0010,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd7);
		send(OP_SRL, PREC_TETRA, 64'h8000_0001_FFFF_FFFF, 64'h0000_0001_0000_0030,
			rand_word(), 8'h00, 1'b0, 6'd9, MODE_APP, 4'd8);
		idle();
		report_test("lane independence", e0);
	endtask

	task automatic test_mask();
		int          e0;
		logic [31:0] r;
		prec_t       pr;
		e0 = errors;
		for (int i = 0; i < 12; i++) begin
			r  = $random(seed);
			pr = (r[9:8] == 2'd3) ? PREC_OCTA : prec_t'(r[9:8]);
			send(opcode_t'(r[7:0] % 8'd9), pr, rand_word(), rand_word(), rand_word(),
				r[23:16], i[0], 6'd17, MODE_SUPER, tag_t'(i));
		end
		idle();
		report_test("byte mask", e0);
	endtask

	// Overflow lands in wyde lanes 3 and 1, then masks hide single lanes
	task automatic test_faults();
		int e0;
		e0 = errors;
		send(OP_ADDV, PREC_WYDE, 64'h7FFF_0001_8000_0005, 64'h0001_0001_FFFF_0003,
			rand_word(), 8'h00, 1'b0, 6'd3, MODE_APP, 4'd1);
		send(OP_ADDV, PREC_WYDE, 64'h7FFF_0001_8000_0005, 64'h0001_0001_FFFF_0003,
			rand_word(), 8'hC0, 1'b0, 6'd3, MODE_APP, 4'd2);
		send(OP_ADDV, PREC_WYDE, 64'h7FFF_0001_8000_0005, 64'h0001_0001_FFFF_0003,
			rand_word(), 8'h4C, 1'b1, 6'd3, MODE_APP, 4'd3);
		send(OP_ADDV, PREC_TETRA, 64'h7FFF_FFFF_0000_0001, 64'h0000_0001_0000_0001,
			rand_word(), 8'h00, 1'b0, 6'd3, MODE_APP, 4'd4);
		send(OP_ADDV, PREC_TETRA, 64'h7FFF_FFFF_0000_0001, 64'h0000_0001_0000_0001,
			rand_word(), 8'hF0, 1'b0, 6'd3, MODE_APP, 4'd5);
		send(OP_SUBV, PREC_OCTA, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001,
			rand_word(), 8'h7F, 1'b0, 6'd3, MODE_APP, 4'd6);
		send(OP_SUBV, PREC_OCTA, 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0001,
			rand_word(), 8'hFF, 1'b1, 6'd3, MODE_APP, 4'd7);
		send(opcode_t'(4'hF), PREC_WYDE, rand_word(), rand_word(), rand_word(), 8'h00, 1'b0,
			6'd3, MODE_APP, 4'd8);
		send(opcode_t'(4'hF), PREC_WYDE, rand_word(), rand_word(), rand_word(), 8'h0C, 1'b0,
			6'd3, MODE_APP, 4'd9);
		idle();
		report_test("faults", e0);
	endtask

	// Register 0, the privileged block and ordinary registers under every mode
	task automatic test_burst();
		int          e0;
		logic [31:0] r;
		regno_t      rd_list [16];
		e0 = errors;
		rd_list = '{6'd0, 6'd56, 6'd57, 6'd60, 6'd63, 6'd5, 6'd33, 6'd0,
			6'd63, 6'd56, 6'd12, 6'd62, 6'd1, 6'd58, 6'd59, 6'd61};
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			send(opcode_t'(r[7:0] % 8'd5), PREC_TETRA, rand_word(), rand_word(), rand_word(),
				8'h00, 1'b0, rd_list[i], mode_t'(i[1:0]), tag_t'(15 - i));
		end
		idle();
		idle();
		report_test("write enables and pipelining", e0);
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		seed        = 68378;
		errors      = 0;
		checks      = 0;
		tests_run   = 0;
		cycle_count = 0;
		issued_now  = 1'b0;
		issued_prev = 1'b0;
		rst_i   <= 1'b1;
		issue_i <= 1'b0;
		op_i    <= OP_ADD;
		prec_i  <= PREC_OCTA;
		a_i     <= '0;
		b_i     <= '0;
		t_i     <= '0;
		mask_i  <= '0;
		zero_i  <= 1'b0;
		rd_i    <= '0;
		mode_i  <= MODE_APP;
		tag_i   <= '0;
		test_reset();
		test_octa();
		test_lanes();
		test_mask();
		test_faults();
		test_burst();
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
